/* logic/oled_link_pkg.sv */
// ************************************************
// OLED link word and state types
// ************************************************
package oled_link_pkg;

   localparam int link_word_bits = 9; // dc in bit 8, byte in 7..0

   // dc=0 bytes that never go out on the wire
   typedef enum logic [7:0] {
      pseudo_end        = 8'h00, // table terminator, dropped by the link
      pseudo_reset_high = 8'h01, // release panel reset, then wait
      pseudo_reset_low  = 8'h02  // assert panel reset, then wait
   } link_pseudo_e;

   typedef enum logic [1:0] {
      ls_idle,       // ready for a word
      ls_shift,      // cs_n low, bits going out
      ls_gap,        // cs_n high between frames
      ls_hold_reset  // rst_n held, counting down
   } link_state_e;

   // current holder of the link
   typedef enum logic [1:0] {own_none, own_init, own_fill} owner_e;

   typedef enum logic [1:0] {is_run, is_drain, is_done} init_state_e;

   typedef enum logic [3:0] {
      fp_idle, fp_col_cmd, fp_col_start, fp_col_end,
      fp_row_cmd, fp_row_start, fp_row_end,
      fp_ram_cmd, fp_pixel, fp_drain
   } fill_phase_e;

endpackage

/* logic/oled_cfg_pkg.sv */
// ************************************************
// SSD1351 panel configuration
// ************************************************
package oled_cfg_pkg;

   localparam int panel_width  = 128;
   localparam int panel_height = 128;
   localparam int coord_bits   = $clog2(panel_width > panel_height ? panel_width : panel_height);
   localparam int init_len     = 50; // entries in the power-up table

   typedef enum logic [7:0] {
      cmd_set_column = 8'h15, cmd_set_row   = 8'h75, cmd_write_ram = 8'h5c,
      cmd_unlock     = 8'hfd, cmd_disp_off  = 8'hae, cmd_mode_norm = 8'ha4,
      cmd_clk_div    = 8'hb3, cmd_mux_ratio = 8'hca, cmd_remap     = 8'ha0,
      cmd_start_line = 8'ha1, cmd_offset    = 8'ha2, cmd_vdd_reg   = 8'hab,
      cmd_seg_vref   = 8'hb4, cmd_contrast  = 8'hc1, cmd_master_cc = 8'hc7,
      cmd_phase_len  = 8'hb1, cmd_enhance   = 8'hb2, cmd_precharge = 8'hbb,
      cmd_prech_2    = 8'hb6, cmd_vcomh     = 8'hbe, cmd_inv_off   = 8'ha6,
      cmd_disp_on    = 8'haf
   } panel_cmd_e;

   // rows of {dc, byte}, a command then its data bytes
   localparam logic [oled_link_pkg::link_word_bits-1:0] init_table [init_len] = '{
      {1'b0, oled_link_pkg::pseudo_reset_low}, {1'b0, oled_link_pkg::pseudo_reset_high},
      {1'b0, cmd_unlock}, 9'h112, {1'b0, cmd_unlock}, 9'h1b1,
      {1'b0, cmd_disp_off}, {1'b0, cmd_mode_norm},
      {1'b0, cmd_set_column}, 9'h100, 9'h17f, {1'b0, cmd_set_row}, 9'h100, 9'h17f,
      {1'b0, cmd_clk_div}, 9'h1f1, {1'b0, cmd_mux_ratio}, 9'h17f,
      {1'b0, cmd_remap}, 9'h174, {1'b0, cmd_start_line}, 9'h100,
      {1'b0, cmd_offset}, 9'h100, {1'b0, cmd_vdd_reg}, 9'h101,
      {1'b0, cmd_seg_vref}, 9'h1a0, 9'h1b5, 9'h155,
      {1'b0, cmd_contrast}, 9'h1c8, 9'h180, 9'h1c0, {1'b0, cmd_master_cc}, 9'h10f,
      {1'b0, cmd_phase_len}, 9'h132, {1'b0, cmd_enhance}, 9'h1a4, 9'h100, 9'h100,
      {1'b0, cmd_precharge}, 9'h117, {1'b0, cmd_prech_2}, 9'h101,
      {1'b0, cmd_vcomh}, 9'h105, {1'b0, cmd_inv_off}, {1'b0, cmd_disp_on}
   };

   // out of range reads give the end marker
   function automatic logic [oled_link_pkg::link_word_bits-1:0] init_rom_word(input int unsigned n);
      if (n < init_len) return init_table[n];
      return '0;
   endfunction

endpackage

/* logic/oled_serial_link.sv */
// ************************************************
// OLED serial link
// ************************************************
`timescale 1ns/1ps

module oled_serial_link #(
   parameter int reset_wait_cycles = 12_500_000 // panel reset hold in clocks
) (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    word_strb,
   input  logic [oled_link_pkg::link_word_bits-1:0] word,
   output logic                                    idle,
   output logic                                    sclk,
   output logic                                    din,
   output logic                                    cs_n,
   output logic                                    dc,
   output logic                                    rst_n
);
   import oled_link_pkg::*;

   localparam int wait_bits = $clog2(reset_wait_cycles + 1);

   link_state_e          state;
   logic                 phase;     // 0 = sclk low half, 1 = high half
   logic [7:0]           shifter;   // msb goes out first
   logic [2:0]           bit_cnt;
   logic [wait_bits-1:0] wait_cnt;
   logic [7:0]           word_byte;
   logic                 pseudo;

   assign word_byte = word[7:0];

   // reset pulses are command words with a special byte
   assign pseudo = !word[link_word_bits-1] &&
                   (word_byte == pseudo_reset_low || word_byte == pseudo_reset_high);

   // pins follow the state directly
   assign idle = (state == ls_idle);
   assign cs_n = (state != ls_shift);
   assign sclk = (state == ls_shift) && phase; // rising edge mid-bit
   assign din  = shifter[7];

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= ls_idle;
         phase    <= 1'b0;
         bit_cnt  <= '0;
         wait_cnt <= '0;
         dc       <= 1'b0;
         rst_n    <= 1'b1; // panel out of reset until told otherwise
      end else begin
         case (state)
            ls_idle: begin
               if (word_strb) begin
                  if (pseudo) begin
                     rst_n    <= (word_byte == pseudo_reset_high);
                     wait_cnt <= wait_bits'(reset_wait_cycles - 1);
                     state    <= ls_hold_reset;
                  end else if (word != '0) begin // end marker is dropped
                     dc      <= word[link_word_bits-1]; // held for the frame
                     phase   <= 1'b0;
                     bit_cnt <= '0;
                     state   <= ls_shift;
                  end
               end
            end
            ls_shift: begin
               phase <= !phase;
               if (phase) begin
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7)
                     state <= ls_gap; // 16 cycles of cs_n low done
               end
            end
            ls_gap: begin
               phase <= !phase; // two cycles with cs_n high
               if (phase)
                  state <= ls_idle;
            end
            ls_hold_reset: begin
               if (wait_cnt == '0)
                  state <= ls_idle;
               else
                  wait_cnt <= wait_cnt - wait_bits'(1);
            end
            default: state <= ls_idle;
         endcase
      end
   end

   // payload shifter
   always_ff @(posedge clk) begin
      if (state == ls_idle && word_strb)
         shifter <= word_byte;
      else if (state == ls_shift && phase)
         shifter <= {shifter[6:0], 1'b0}; // next bit after the high half
   end

endmodule

/* logic/oled_init_seq.sv */
// ************************************************
// OLED power-up sequencer
// ************************************************
`timescale 1ns/1ps

module oled_init_seq (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    ready,
   output logic                                    req,
   output logic                                    word_strb,
   output logic [oled_link_pkg::link_word_bits-1:0] word,
   output logic                                    init_done
);
   import oled_cfg_pkg::*;
   import oled_link_pkg::*;

   localparam int idx_bits = $clog2(init_len);

   init_state_e         state;
   logic [idx_bits-1:0] idx;     // current table entry
   logic                last_entry;

   assign last_entry = (idx == idx_bits'(init_len - 1));

   // table lookup is pure logic
   assign word = init_rom_word(int'(idx));

   // link is ours for the whole sequence
   assign req = (state != is_done);

   // one word per granted idle cycle, link drops idle right after
   assign word_strb = ready && (state == is_run);

   assign init_done = (state == is_done);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= is_run;
         idx   <= '0;
      end else begin
         case (state)
            is_run: begin
               if (word_strb) begin
                  if (last_entry)
                     state <= is_drain; // display on is in flight
                  else
                     idx <= idx + idx_bits'(1);
               end
            end
            is_drain: begin
               // ready again means the last frame has left the link
               if (ready)
                  state <= is_done;
            end
            is_done: begin
               state <= is_done; // parked, req stays low
            end
            default: state <= is_run;
         endcase
      end
   end

endmodule

/* logic/oled_pixel_fill.sv */
// ************************************************
// OLED rectangle fill
// ************************************************
`timescale 1ns/1ps

module oled_pixel_fill (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    init_done,
   input  logic                                    fill_start,
   input  logic [oled_cfg_pkg::coord_bits-1:0]     x0,
   input  logic [oled_cfg_pkg::coord_bits-1:0]     x1,
   input  logic [oled_cfg_pkg::coord_bits-1:0]     y0,
   input  logic [oled_cfg_pkg::coord_bits-1:0]     y1,
   input  logic [15:0]                             colour,
   input  logic                                    ready,
   output logic                                    req,
   output logic                                    word_strb,
   output logic [oled_link_pkg::link_word_bits-1:0] word,
   output logic                                    fill_done
);
   import oled_cfg_pkg::*;
   import oled_link_pkg::*;

   fill_phase_e           phase;
   logic [coord_bits-1:0] x0_q, x1_q, y0_q, y1_q; // latched window
   logic [15:0]           colour_q;
   logic [15:0]           span_x, span_y, area;
   logic [15:0]           pix_cnt;  // pixels still to send
   logic                  byte_hi;  // high colour byte next
   logic                  accept;

   assign span_x = 16'(x1) - 16'(x0) + 16'd1; // corners are ordered
   assign span_y = 16'(y1) - 16'(y0) + 16'd1;
   assign area   = span_x * span_y;

   assign accept    = (phase == fp_idle) && fill_start && init_done; // else dropped
   assign req       = (phase != fp_idle);
   assign word_strb = ready && (phase != fp_idle) && (phase != fp_drain);
   assign fill_done = ready && (phase == fp_drain); // phase leaves drain next cycle

   always_comb begin
      case (phase)
         fp_col_cmd:   word = {1'b0, cmd_set_column};
         fp_col_start: word = {1'b1, 8'(x0_q)};
         fp_col_end:   word = {1'b1, 8'(x1_q)};
         fp_row_cmd:   word = {1'b0, cmd_set_row};
         fp_row_start: word = {1'b1, 8'(y0_q)};
         fp_row_end:   word = {1'b1, 8'(y1_q)};
         fp_ram_cmd:   word = {1'b0, cmd_write_ram};
         fp_pixel:     word = {1'b1, byte_hi ? colour_q[15:8] : colour_q[7:0]}; // rgb565
         default:      word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         phase   <= fp_idle;
         pix_cnt <= '0;
         byte_hi <= 1'b1;
      end else begin
         case (phase)
            fp_idle: if (accept) begin
               phase   <= fp_col_cmd;
               pix_cnt <= area;
               byte_hi <= 1'b1;
            end
            fp_col_cmd:   if (word_strb) phase <= fp_col_start;
            fp_col_start: if (word_strb) phase <= fp_col_end;
            fp_col_end:   if (word_strb) phase <= fp_row_cmd;
            fp_row_cmd:   if (word_strb) phase <= fp_row_start;
            fp_row_start: if (word_strb) phase <= fp_row_end;
            fp_row_end:   if (word_strb) phase <= fp_ram_cmd;
            fp_ram_cmd:   if (word_strb) phase <= fp_pixel;
            fp_pixel: if (word_strb) begin
               byte_hi <= !byte_hi;
               if (!byte_hi) begin // pixel complete after low byte
                  pix_cnt <= pix_cnt - 16'd1;
                  if (pix_cnt == 16'd1)
                     phase <= fp_drain;
               end
            end
            fp_drain: if (ready) phase <= fp_idle; // last frame done
            default: phase <= fp_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         x0_q     <= x0;
         x1_q     <= x1;
         y0_q     <= y0;
         y1_q     <= y1;
         colour_q <= colour;
      end
   end

endmodule

/* logic/oled_link_arbiter.sv */
// ************************************************
// OLED link arbiter
// ************************************************
`timescale 1ns/1ps

module oled_link_arbiter (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    init_req,
   input  logic                                    init_strb,
   input  logic [oled_link_pkg::link_word_bits-1:0] init_word,
   input  logic                                    fill_req,
   input  logic                                    fill_strb,
   input  logic [oled_link_pkg::link_word_bits-1:0] fill_word,
   input  logic                                    link_idle,
   output logic                                    init_ready,
   output logic                                    fill_ready,
   output logic                                    link_strb,
   output logic [oled_link_pkg::link_word_bits-1:0] link_word
);
   import oled_link_pkg::*;

   owner_e owner;

   assign init_ready = (owner == own_init) && link_idle;
   assign fill_ready = (owner == own_fill) && link_idle;

   // only the owner reaches the link
   assign link_strb = (owner == own_init) ? init_strb :
                      (owner == own_fill) ? fill_strb : 1'b0;
   assign link_word = (owner == own_fill) ? fill_word : init_word;

   always_ff @(posedge clk) begin
      if (reset) begin
         owner <= own_none;
      end else begin
         case (owner)
            own_none: if (link_idle) begin // init wins ties
               if (init_req)
                  owner <= own_init;
               else if (fill_req)
                  owner <= own_fill;
            end
            own_init: if (!init_req) owner <= own_none;
            own_fill: if (!fill_req) owner <= own_none;
            default:  owner <= own_none;
         endcase
      end
   end

endmodule

/* logic/oled_ctrl.sv */
// ************************************************
// OLED controller top
// ************************************************
`timescale 1ns/1ps

module oled_ctrl #(
   parameter int reset_wait_cycles = 12_500_000 // about 0.5 s at 25 MHz
) (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                fill_start,
   input  logic [oled_cfg_pkg::coord_bits-1:0] x0,
   input  logic [oled_cfg_pkg::coord_bits-1:0] x1,
   input  logic [oled_cfg_pkg::coord_bits-1:0] y0,
   input  logic [oled_cfg_pkg::coord_bits-1:0] y1,
   input  logic [15:0]                         colour,
   output logic                                init_done,
   output logic                                fill_done,
   output logic                                sclk,
   output logic                                din,
   output logic                                cs_n,
   output logic                                dc,
   output logic                                rst_n
);
   import oled_link_pkg::*;

   logic                      init_req, init_strb, init_ready;
   logic                      fill_req, fill_strb, fill_ready;
   logic                      link_strb, link_idle;
   logic [link_word_bits-1:0] init_word, fill_word, link_word;

   oled_init_seq init_seq_i (
      .clk(clk), .reset(reset), .ready(init_ready),
      .req(init_req), .word_strb(init_strb), .word(init_word), .init_done(init_done)
   );

   // fill waits for init_done before taking any start
   oled_pixel_fill pixel_fill_i (
      .clk(clk), .reset(reset), .init_done(init_done), .fill_start(fill_start),
      .x0(x0), .x1(x1), .y0(y0), .y1(y1), .colour(colour), .ready(fill_ready),
      .req(fill_req), .word_strb(fill_strb), .word(fill_word), .fill_done(fill_done)
   );

   oled_link_arbiter link_arbiter_i (
      .clk(clk), .reset(reset),
      .init_req(init_req), .init_strb(init_strb), .init_word(init_word),
      .fill_req(fill_req), .fill_strb(fill_strb), .fill_word(fill_word),
      .link_idle(link_idle), .init_ready(init_ready), .fill_ready(fill_ready),
      .link_strb(link_strb), .link_word(link_word)
   );

   oled_serial_link #(.reset_wait_cycles(reset_wait_cycles)) serial_link_i (
      .clk(clk), .reset(reset), .word_strb(link_strb), .word(link_word), .idle(link_idle),
      .sclk(sclk), .din(din), .cs_n(cs_n), .dc(dc), .rst_n(rst_n)
   );

endmodule

/* dv/oled_ctrl_assert.sv */
// ************************************************
// OLED link protocol checks
// ************************************************
`timescale 1ns/1ps

module oled_link_assert (
   input logic clk,
   input logic reset,
   input logic word_strb,
   input logic idle,
   input logic sclk,
   input logic cs_n,
   input logic dc,
   input logic rst_n
);

   // no clock edges outside a frame
   sclk_in_frame: assert property (@(posedge clk) disable iff (reset) cs_n |-> !sclk)
      else $error("sclk high while cs_n is high");

   // dc held from the first frame cycle on
   dc_stable: assert property (@(posedge clk) disable iff (reset)
      (!cs_n && !$past(cs_n)) |-> $stable(dc))
      else $error("dc changed inside a frame");

   cs_in_reset: assert property (@(posedge clk) disable iff (reset) !rst_n |-> cs_n)
      else $error("cs_n low while the panel is in reset");

   // clients strobe only on grant and idle
   strb_on_idle: assert property (@(posedge clk) disable iff (reset) word_strb |-> idle)
      else $error("word strobe while the link is busy");

endmodule

bind oled_serial_link oled_link_assert link_assert_i (
   .clk(clk), .reset(reset), .word_strb(word_strb), .idle(idle), .sclk(sclk),
   .cs_n(cs_n), .dc(dc), .rst_n(rst_n)
);

/* dv/oled_ctrl_tb.sv */
// ************************************************
// OLED controller testbench
// ************************************************
`timescale 1ns/1ps

module oled_ctrl_tb;
   import oled_cfg_pkg::*;

   localparam int reset_wait = 200; // short panel reset for simulation
   localparam int kind_init = 0;
   localparam int kind_fill = 1;
   // init, 1x1 fill, 3x2 fill, ten fills of up to 4x4
   localparam int max_words = (init_len - 2) + 9 + 19 + 10 * (7 + 2 * 16);
   localparam int timeout_cycles = max_words * 19 + 2 * reset_wait + 2000;

   logic clk, reset, fill_start;
   logic [coord_bits-1:0] x0, x1, y0, y1;
   logic [15:0] colour;
   logic init_done, fill_done, sclk, din, cs_n, dc, rst_n;

   logic [8:0]  obs_q[$];          // decoded {dc, byte}
   logic [8:0]  exp_q[$];          // from the reference model
   logic        rst_val_q[$];
   int          rst_cyc_q[$];      // cycle of each rst_n change
   int          obs_rd = 0, exp_rd = 0;
   int          cyc = 0, done_cnt = 0, fills_expected = 0;
   int          first_cs_cyc = -1;
   int          rx_bits = 0;
   logic [7:0]  rx_byte;
   logic        rst_prev;
   logic [31:0] lfsr = 32'h8a305681;
   string       test_name;

   oled_ctrl #(.reset_wait_cycles(reset_wait)) oled_ctrl_i (
      .clk(clk), .reset(reset), .fill_start(fill_start),
      .x0(x0), .x1(x1), .y0(y0), .y1(y1), .colour(colour),
      .init_done(init_done), .fill_done(fill_done),
      .sclk(sclk), .din(din), .cs_n(cs_n), .dc(dc), .rst_n(rst_n)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // x^32 + x^22 + x^2 + x + 1 stepped once per bit
   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] v;
      logic        fb;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[14:0], fb};
      end
      return v;
   endfunction

   // appends the words the panel should see to exp_q
   function automatic void expected_words(input int kind,
         input logic [coord_bits-1:0] wx0, wx1, wy0, wy1, input logic [15:0] col);
      int area;
      int n;
      if (kind == kind_init) begin
         for (n = 2; n < init_len; n++)
            exp_q.push_back(init_rom_word(n)); // pseudo entries 0 and 1 stay off the wire
      end else begin
         exp_q.push_back(9'h015); // column window
         exp_q.push_back({1'b1, 8'(wx0)});
         exp_q.push_back({1'b1, 8'(wx1)});
         exp_q.push_back(9'h075); // row window
         exp_q.push_back({1'b1, 8'(wy0)});
         exp_q.push_back({1'b1, 8'(wy1)});
         exp_q.push_back(9'h05c); // write ram
         area = (int'(wx1) - int'(wx0) + 1) * (int'(wy1) - int'(wy0) + 1);
         for (n = 0; n < area; n++) begin
            exp_q.push_back({1'b1, col[15:8]}); // high byte first
            exp_q.push_back({1'b1, col[7:0]});
         end
      end
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
         input logic [31:0] actual);
      if (expected !== actual) begin
         $display("** Error: %s expected %0h actual %0h", name, expected, actual);
         $display("Done: errors found");
         $fatal(1, "value mismatch");
      end
   endtask

   // one-cycle start pulse that adds no expected words
   task automatic pulse_start(input logic [coord_bits-1:0] sx0, sx1, sy0, sy1,
         input logic [15:0] scol);
      @(negedge clk);
      x0 = sx0;
      x1 = sx1;
      y0 = sy0;
      y1 = sy1;
      colour = scol;
      fill_start = 1'b1;
      @(negedge clk);
      fill_start = 1'b0;
   endtask

   task automatic start_fill(input logic [coord_bits-1:0] sx0, sx1, sy0, sy1,
         input logic [15:0] scol);
      expected_words(kind_fill, sx0, sx1, sy0, sy1, scol);
      fills_expected++;
      pulse_start(sx0, sx1, sy0, sy1, scol);
   endtask

   task automatic finish_fill();
      while (!fill_done) @(negedge clk);
      check_value({test_name, " words before fill_done"}, exp_q.size(), obs_q.size());
      repeat (24) @(negedge clk); // room for any stray word
      check_value({test_name, " fill_done count"}, fills_expected, done_cnt);
      check_value({test_name, " expected left"}, exp_q.size(), exp_rd);
      check_value({test_name, " decoded left"}, obs_q.size(), obs_rd);
   endtask

   // serial decoder rebuilds each msb-first byte
   always @(posedge sclk) begin
      if (!cs_n) begin
         rx_byte = {rx_byte[6:0], din};
         rx_bits++;
         if (rx_bits == 8) begin
            obs_q.push_back({dc, rx_byte});
            rx_bits = 0;
         end
      end
   end

   // cycle count, reset edges, fill_done pulses, timeout
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (reset) begin
         rst_prev <= 1'b1;
      end else begin
         if (rst_n !== rst_prev) begin
            rst_val_q.push_back(rst_n);
            rst_cyc_q.push_back(cyc);
            rst_prev <= rst_n;
         end
         if (!cs_n && first_cs_cyc < 0)
            first_cs_cyc <= cyc;
         if (fill_done)
            done_cnt <= done_cnt + 1;
      end
      if (cyc >= timeout_cycles) begin
         $display("run hung: no end after %0d cycles", cyc);
         $display("Done: errors found");
         $fatal(1, "timeout");
      end
   end

   // compares decoded words in order
   always @(negedge clk) begin
      if (obs_rd < obs_q.size()) begin
         if (exp_rd >= exp_q.size()) begin
            $display("unexpected word %h decoded during %s", obs_q[obs_rd], test_name);
            $display("Done: errors found");
            $fatal(1, "extra word on the link");
         end else begin
            check_value(test_name, 32'(exp_q[exp_rd]), 32'(obs_q[obs_rd]));
            obs_rd++;
            exp_rd++;
         end
      end
   end

   initial begin
      logic [coord_bits-1:0] rx0, rx1, ry0, ry1;
      int t;
      reset = 1'b1;
      fill_start = 1'b0;
      x0 = '0;
      x1 = '0;
      y0 = '0;
      y1 = '0;
      colour = '0;
      test_name = "init";
      expected_words(kind_init, '0, '0, '0, '0, '0);
      repeat (16) @(negedge clk);
      reset = 1'b0;

      // starts while init runs must be dropped
      repeat (50) @(negedge clk);
      pulse_start(7'd1, 7'd2, 7'd3, 7'd4, 16'h1234); // inside the reset wait
      while (obs_q.size() < 10) @(negedge clk);
      pulse_start(7'd0, 7'd9, 7'd0, 7'd9, 16'h4321); // among the table words
      while (!init_done) @(negedge clk);
      check_value("init words before init_done", init_len - 2, obs_q.size());
      repeat (4) @(negedge clk);
      check_value("init expected left", exp_q.size(), exp_rd);
      check_value("init fill_done count", 0, done_cnt);
      check_value("rst_n changes", 2, rst_cyc_q.size());
      check_value("rst_n first level", 0, 32'(rst_val_q[0]));
      check_value("rst_n second level", 1, 32'(rst_val_q[1]));
      check_value("rst_n low length", 1, 32'(rst_cyc_q[1] - rst_cyc_q[0] >= reset_wait));
      check_value("cs_n quiet in reset wait", 1, 32'(first_cs_cyc - rst_cyc_q[1] >= reset_wait));

      test_name = "fill 1x1";
      start_fill(7'd5, 7'd5, 7'd7, 7'd7, 16'hf81f);
      finish_fill();

      test_name = "fill with second start";
      start_fill(7'd10, 7'd12, 7'd20, 7'd21, 16'h07e0);
      repeat (40) @(negedge clk); // fill still sending
      pulse_start(7'd0, 7'd127, 7'd0, 7'd127, 16'hffff);
      finish_fill();

      for (t = 0; t < 10; t++) begin
         rx0 = coord_bits'(take_bits(7) % 16'd125); // room for an extent of 4
         rx1 = rx0 + coord_bits'(take_bits(2));
         ry0 = coord_bits'(take_bits(7) % 16'd125);
         ry1 = ry0 + coord_bits'(take_bits(2));
         test_name = $sformatf("random fill %0d", t);
         start_fill(rx0, rx1, ry0, ry1, take_bits(16));
         finish_fill();
      end

      if (exp_rd == exp_q.size() && obs_rd == obs_q.size()) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("Done: errors found");
         $fatal(1, "words left over at the end");
      end
   end

endmodule

/* oled_ctrl.f */
logic/oled_link_pkg.sv
logic/oled_cfg_pkg.sv
logic/oled_serial_link.sv
logic/oled_init_seq.sv
logic/oled_pixel_fill.sv
logic/oled_link_arbiter.sv
logic/oled_ctrl.sv
dv/oled_ctrl_assert.sv
dv/oled_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the oled_ctrl testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module oled_ctrl_tb \
   -f oled_ctrl.f \
   -o oled_ctrl_sim

# exit status of the simulation is the result
./obj_dir/oled_ctrl_sim
